/* source/dsq_pkg.sv */
// ---------------------------------------------------------------------
// Shared widths, iteration counts, types and structs of the
// divide/square-root unit
// ---------------------------------------------------------------------

package dsq_pkg;

  // ---------------------------------------------------------------------
  // Widths and iteration counts
  // ---------------------------------------------------------------------
  localparam int unsigned OPERAND_W  = 16;
  localparam int unsigned TAG_W      = 4;
  // One quotient bit per cycle
  localparam int unsigned DIV_STEPS  = 16;
  // One root bit per cycle, two radicand bits consumed each
  localparam int unsigned SQRT_STEPS = 8;
  // Wide enough to hold DIV_STEPS itself
  localparam int unsigned STEP_CNT_W = 5;

  // ---------------------------------------------------------------------
  // Types
  // ---------------------------------------------------------------------
  typedef logic [OPERAND_W-1:0]  operand_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [STEP_CNT_W-1:0] step_cnt_t;

  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } op_e;

  typedef struct packed {
    logic div_by_zero;
    logic inexact;
  } dsq_status_t;

  // Request as it enters the unit, operand_b unused for OP_SQRT
  typedef struct packed {
    op_e      op;
    operand_t operand_a;
    operand_t operand_b;
    tag_t     tag;
  } dsq_req_t;

  typedef struct packed {
    operand_t    result;
    dsq_status_t status;
    tag_t        tag;
  } dsq_rsp_t;

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,
    HOLD = 2'd2
  } seq_state_e;

endpackage

/* source/dsq_input_stage.sv */
// ---------------------------------------------------------------------
// Request register slice with valid/ready handshake and flush clear
// ---------------------------------------------------------------------

`timescale 1ns/100ps

module dsq_input_stage (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              flush_i,
  // Upstream side
  input  dsq_pkg::dsq_req_t in_req_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  // Towards the sequencer
  output dsq_pkg::dsq_req_t stage_req_o,
  output logic              stage_valid_o,
  input  logic              stage_ready_i
);

  dsq_pkg::dsq_req_t req_q;
  logic              valid_q;

  // Slice can take a new item when empty or when its content leaves now
  assign in_ready_o = ~valid_q | stage_ready_i;

  // Valid bit, flush drops whatever sits in the slice
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // Payload only moves on an accepted item
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      req_q <= in_req_i;
    end
  end

  assign stage_req_o   = req_q;
  assign stage_valid_o = valid_q;

  // ---------------------------------------------------------------------
  // Protocol check on the upstream side
  // ---------------------------------------------------------------------
  // Once offered, a request keeps valid and data until taken
  a_in_req_stable : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (in_valid_i && !in_ready_o && !flush_i) |=> (in_valid_i && $stable(in_req_i))
  ) else $error("Input request changed or dropped before acceptance");

endmodule

/* source/dsq_op_sequencer.sv */
// ---------------------------------------------------------------------
// Operation sequencer with IDLE/BUSY/HOLD FSM, start strobes,
// tag capture, result hold register and output select
// ---------------------------------------------------------------------

`timescale 1ns/100ps

module dsq_op_sequencer (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 flush_i,
  // From the input stage
  input  dsq_pkg::dsq_req_t    stage_req_i,
  input  logic                 stage_valid_i,
  output logic                 stage_ready_o,
  // To the iterative unit
  output logic                 start_div_o,
  output logic                 start_sqrt_o,
  output dsq_pkg::operand_t    operand_a_o,
  output dsq_pkg::operand_t    operand_b_o,
  // From the iterative unit
  input  logic                 unit_ready_i,
  input  logic                 unit_done_i,
  input  dsq_pkg::operand_t    unit_result_i,
  input  dsq_pkg::dsq_status_t unit_status_i,
  // To the output stage
  output dsq_pkg::dsq_rsp_t    seq_rsp_o,
  output logic                 seq_valid_o,
  input  logic                 seq_ready_i,
  output logic                 seq_busy_o
);

  dsq_pkg::seq_state_e state_q, state_d;
  logic                can_start;
  logic                hold_en;
  dsq_pkg::tag_t       tag_q;
  dsq_pkg::dsq_rsp_t   held_rsp_q;
  dsq_pkg::dsq_rsp_t   live_rsp;

  // New work may only launch into an idle unit and never during flush
  assign can_start = stage_valid_i & unit_ready_i & ~flush_i;

  // ---------------------------------------------------------------------
  // Control FSM
  // ---------------------------------------------------------------------
  always_comb begin
    state_d       = state_q;
    stage_ready_o = 1'b0;
    seq_valid_o   = 1'b0;
    seq_busy_o    = 1'b0;
    hold_en       = 1'b0;

    unique case (state_q)
      dsq_pkg::IDLE: begin
        if (can_start) begin
          stage_ready_o = 1'b1;
          state_d       = dsq_pkg::BUSY;
        end
      end
      dsq_pkg::BUSY: begin
        seq_busy_o = 1'b1;
        if (unit_done_i) begin
          // Offer the result straight from the unit
          seq_valid_o = 1'b1;
          if (seq_ready_i) begin
            state_d = dsq_pkg::IDLE;
            // Back-to-back launch in the same cycle the result leaves
            if (can_start) begin
              stage_ready_o = 1'b1;
              state_d       = dsq_pkg::BUSY;
            end
          end else begin
            // Downstream stalls, park the response
            hold_en = ~flush_i;
            state_d = dsq_pkg::HOLD;
          end
        end
      end
      dsq_pkg::HOLD: begin
        seq_busy_o  = 1'b1;
        seq_valid_o = 1'b1;
        if (seq_ready_i) begin
          state_d = dsq_pkg::IDLE;
          if (can_start) begin
            stage_ready_o = 1'b1;
            state_d       = dsq_pkg::BUSY;
          end
        end
      end
      default: state_d = dsq_pkg::IDLE;
    endcase

    // Flush cancels everything in flight
    if (flush_i) begin
      seq_valid_o = 1'b0;
      seq_busy_o  = 1'b0;
      state_d     = dsq_pkg::IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= dsq_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Start strobes coincide with the acceptance cycle
  assign start_div_o  = stage_ready_o & (stage_req_i.op == dsq_pkg::OP_DIV);
  assign start_sqrt_o = stage_ready_o & (stage_req_i.op == dsq_pkg::OP_SQRT);
  assign operand_a_o  = stage_req_i.operand_a;
  assign operand_b_o  = stage_req_i.operand_b;

  // ---------------------------------------------------------------------
  // Tag capture and hold register
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (stage_ready_o) begin
      tag_q <= stage_req_i.tag;
    end
  end

  assign live_rsp.result = unit_result_i;
  assign live_rsp.status = unit_status_i;
  assign live_rsp.tag    = tag_q;

  always_ff @(posedge clk_i) begin
    if (hold_en) begin
      held_rsp_q <= live_rsp;
    end
  end

  // Held response wins over the live one
  assign seq_rsp_o = (state_q == dsq_pkg::HOLD) ? held_rsp_q : live_rsp;

  // Idle means no unit result arriving and no response offered
  a_no_valid_in_idle : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (state_q == dsq_pkg::IDLE) |-> !(seq_valid_o || unit_done_i)
  ) else $error("Response or unit result while sequencer idle");

endmodule

/* source/dsq_iter_unit.sv */
// ---------------------------------------------------------------------
// Restoring divider and integer square root, one result bit per cycle
// ---------------------------------------------------------------------

`timescale 1ns/100ps

module dsq_iter_unit (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 kill_i,
  input  logic                 start_div_i,
  input  logic                 start_sqrt_i,
  input  dsq_pkg::operand_t    operand_a_i,
  input  dsq_pkg::operand_t    operand_b_i,
  output logic                 unit_ready_o,
  output logic                 unit_done_o,
  output dsq_pkg::operand_t    result_o,
  output dsq_pkg::dsq_status_t status_o
);

  localparam int unsigned W = dsq_pkg::OPERAND_W;

  // Control state
  logic                busy_q;
  logic                done_q;
  logic                is_sqrt_q;
  dsq_pkg::step_cnt_t  cnt_q;
  // Datapath
  // quot_q shifts the dividend/radicand out at the top
  // Quotient bits enter at the bottom for division
  dsq_pkg::operand_t   quot_q;
  dsq_pkg::operand_t   rem_q;
  dsq_pkg::operand_t   root_q;
  dsq_pkg::operand_t   divisor_q;
  dsq_pkg::operand_t   result_q;
  dsq_pkg::dsq_status_t status_q;

  logic                start;
  logic                last_step;
  logic                div_by_zero;
  logic                fits;
  logic [W:0]          trial_rem;
  logic [W:0]          trial_sub;
  logic [W:0]          trial_diff;
  dsq_pkg::operand_t   rem_nxt;
  dsq_pkg::operand_t   quot_nxt;
  dsq_pkg::operand_t   root_nxt;
  dsq_pkg::operand_t   result_d;
  dsq_pkg::dsq_status_t status_d;

  assign start       = start_div_i | start_sqrt_i;
  assign last_step   = busy_q & (cnt_q == dsq_pkg::step_cnt_t'(1));
  assign div_by_zero = ~is_sqrt_q & (divisor_q == '0);

  // ---------------------------------------------------------------------
  // One restoring step, shared compare/subtract for both operations
  // ---------------------------------------------------------------------
  always_comb begin
    if (is_sqrt_q) begin
      // Bring down two radicand bits, trial is 4*root+1
      trial_rem = {rem_q[W-2:0], quot_q[W-1:W-2]};
      trial_sub = {root_q[W-2:0], 2'b01};
      quot_nxt  = {quot_q[W-3:0], 2'b00};
    end else begin
      // Bring down one dividend bit
      trial_rem = {rem_q, quot_q[W-1]};
      trial_sub = {1'b0, divisor_q};
      quot_nxt  = {quot_q[W-2:0], (trial_rem >= trial_sub)};
    end
    fits       = trial_rem >= trial_sub;
    trial_diff = trial_rem - trial_sub;
    // Restore on a failed trial, result always fits W bits
    rem_nxt    = fits ? trial_diff[W-1:0] : trial_rem[W-1:0];
    root_nxt   = {root_q[W-2:0], fits};
  end

  // Final result and flags, taken from the last step's values
  always_comb begin
    result_d             = is_sqrt_q ? root_nxt : quot_nxt;
    status_d.div_by_zero = div_by_zero;
    // No meaningful remainder for a zero divisor
    status_d.inexact     = (rem_nxt != '0) & ~div_by_zero;
    if (div_by_zero) begin
      result_d = '1;
    end
  end

  // ---------------------------------------------------------------------
  // Control and step counter
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i || kill_i) begin
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      is_sqrt_q <= 1'b0;
      cnt_q     <= '0;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        busy_q    <= 1'b1;
        is_sqrt_q <= start_sqrt_i;
        // Zero divisor runs the full count too, latency stays per-op
        cnt_q     <= start_sqrt_i ? dsq_pkg::step_cnt_t'(dsq_pkg::SQRT_STEPS)
                                  : dsq_pkg::step_cnt_t'(dsq_pkg::DIV_STEPS);
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
        if (last_step) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Datapath registers
  always_ff @(posedge clk_i) begin
    if (start) begin
      quot_q    <= operand_a_i;
      divisor_q <= operand_b_i;
      rem_q     <= '0;
      root_q    <= '0;
    end else if (busy_q) begin
      quot_q <= quot_nxt;
      rem_q  <= rem_nxt;
      if (is_sqrt_q) begin
        root_q <= root_nxt;
      end
      if (last_step) begin
        result_q <= result_d;
        status_q <= status_d;
      end
    end
  end

  // Unit is free again in the done cycle
  assign unit_ready_o = ~busy_q;
  assign unit_done_o  = done_q;
  assign result_o     = result_q;
  assign status_o     = status_q;

  a_start_when_ready : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (start_div_i || start_sqrt_i) |-> unit_ready_o
  ) else $error("Start issued while unit busy");

  a_single_start : assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(start_div_i && start_sqrt_i)
  ) else $error("Divide and square-root started together");

endmodule

/* source/dsq_output_stage.sv */
// ---------------------------------------------------------------------
// Response register slice with valid/ready handshake and flush clear
// ---------------------------------------------------------------------

`timescale 1ns/100ps

module dsq_output_stage (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              flush_i,
  // From the sequencer
  input  dsq_pkg::dsq_rsp_t seq_rsp_i,
  input  logic              seq_valid_i,
  output logic              seq_ready_o,
  // Downstream side
  output dsq_pkg::dsq_rsp_t out_rsp_o,
  output logic              out_valid_o,
  input  logic              out_ready_i
);

  dsq_pkg::dsq_rsp_t rsp_q;
  logic              valid_q;

  // Ready when empty or draining this cycle
  assign seq_ready_o = ~valid_q | out_ready_i;

  // Valid bit
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (seq_ready_o) begin
      valid_q <= seq_valid_i;
    end
  end

  // Response payload
  always_ff @(posedge clk_i) begin
    if (seq_valid_i && seq_ready_o) begin
      rsp_q <= seq_rsp_i;
    end
  end

  assign out_rsp_o   = rsp_q;
  assign out_valid_o = valid_q;

endmodule

/* source/dsq_top.sv */
// ---------------------------------------------------------------------
// Divide/square-root top: input slice, sequencer, iterative unit,
// output slice and busy indication
// ---------------------------------------------------------------------

`timescale 1ns/100ps

module dsq_top (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              flush_i,
  // Request side
  input  dsq_pkg::dsq_req_t in_req_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  // Response side
  output dsq_pkg::dsq_rsp_t out_rsp_o,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  // Anything in flight
  output logic              busy_o
);

  dsq_pkg::dsq_req_t    stage_req;
  logic                 stage_valid;
  logic                 stage_ready;
  logic                 start_div;
  logic                 start_sqrt;
  dsq_pkg::operand_t    operand_a;
  dsq_pkg::operand_t    operand_b;
  logic                 unit_ready;
  logic                 unit_done;
  dsq_pkg::operand_t    unit_result;
  dsq_pkg::dsq_status_t unit_status;
  dsq_pkg::dsq_rsp_t    seq_rsp;
  logic                 seq_valid;
  logic                 seq_ready;
  logic                 seq_busy;

  dsq_input_stage u_input_stage (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .flush_i       (flush_i),
    .in_req_i      (in_req_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .stage_req_o   (stage_req),
    .stage_valid_o (stage_valid),
    .stage_ready_i (stage_ready)
  );

  dsq_op_sequencer u_op_sequencer (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .flush_i       (flush_i),
    .stage_req_i   (stage_req),
    .stage_valid_i (stage_valid),
    .stage_ready_o (stage_ready),
    .start_div_o   (start_div),
    .start_sqrt_o  (start_sqrt),
    .operand_a_o   (operand_a),
    .operand_b_o   (operand_b),
    .unit_ready_i  (unit_ready),
    .unit_done_i   (unit_done),
    .unit_result_i (unit_result),
    .unit_status_i (unit_status),
    .seq_rsp_o     (seq_rsp),
    .seq_valid_o   (seq_valid),
    .seq_ready_i   (seq_ready),
    .seq_busy_o    (seq_busy)
  );

  // Flush kills the running iteration
  dsq_iter_unit u_iter_unit (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .kill_i       (flush_i),
    .start_div_i  (start_div),
    .start_sqrt_i (start_sqrt),
    .operand_a_i  (operand_a),
    .operand_b_i  (operand_b),
    .unit_ready_o (unit_ready),
    .unit_done_o  (unit_done),
    .result_o     (unit_result),
    .status_o     (unit_status)
  );

  dsq_output_stage u_output_stage (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .flush_i     (flush_i),
    .seq_rsp_i   (seq_rsp),
    .seq_valid_i (seq_valid),
    .seq_ready_o (seq_ready),
    .out_rsp_o   (out_rsp_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

  assign busy_o = stage_valid | seq_busy | out_valid_o;

endmodule

/* dv/dsq_tb_vectors.svh */
// ----------------------------------------------------------------------
// Test table for the divide/square-root testbench: stimulus, stall and
// flush control, expected responses
// ----------------------------------------------------------------------

`ifndef DSQ_TB_VECTORS_SVH
`define DSQ_TB_VECTORS_SVH

// Columns: index, name, op, operand_a, operand_b, tag, stall, flush,
// expected result, expected status {div_by_zero, inexact}

typedef struct packed {
  dsq_pkg::op_e         op;
  dsq_pkg::operand_t    a;
  dsq_pkg::operand_t    b;
  dsq_pkg::tag_t        tag;
  logic [3:0]           stall;
  logic                 flush;
  dsq_pkg::operand_t    exp_result;
  dsq_pkg::dsq_status_t exp_status;
} vec_t;

localparam int           NUM_VECS     = 16;
// Stall column value that asks for a random count of 0 to 7
localparam logic [3:0]   RANDOM_STALL = 4'hF;
localparam dsq_pkg::op_e DIV          = dsq_pkg::OP_DIV;
localparam dsq_pkg::op_e SQRT         = dsq_pkg::OP_SQRT;

vec_t  vec_tab  [NUM_VECS];
string vec_name [NUM_VECS];

// One table row
task automatic define_entry(input int idx, input string name, input dsq_pkg::op_e op,
                            input dsq_pkg::operand_t a, input dsq_pkg::operand_t b,
                            input dsq_pkg::tag_t tag, input logic [3:0] stall,
                            input logic flush, input dsq_pkg::operand_t res,
                            input logic [1:0] st);
  vec_name[idx]            = name;
  vec_tab[idx].op          = op;
  vec_tab[idx].a           = a;
  vec_tab[idx].b           = b;
  vec_tab[idx].tag         = tag;
  vec_tab[idx].stall       = stall;
  vec_tab[idx].flush       = flush;
  vec_tab[idx].exp_result  = res;
  vec_tab[idx].exp_status  = st;
endtask

task automatic fill_table();
  // Divisions
  define_entry(0,  "div_exact",    DIV,  16'd100,   16'd5,   4'h1, 4'd0, 1'b0, 16'd20,   2'b00);
  define_entry(1,  "div_inexact",  DIV,  16'd1000,  16'd7,   4'h2, 4'd3, 1'b0, 16'd142,  2'b01);
  define_entry(2,  "div_max",      DIV,  16'd65535, 16'd1,   4'h3, 4'd0, 1'b0, 16'hFFFF, 2'b00);
  define_entry(3,  "div_small",    DIV,  16'd5,     16'd9,   4'h4, 4'hF, 1'b0, 16'd0,    2'b01);
  define_entry(4,  "div_by_zero",  DIV,  16'd1234,  16'd0,   4'h5, 4'd2, 1'b0, 16'hFFFF, 2'b10);
  define_entry(5,  "div_big",      DIV,  16'd65535, 16'd255, 4'h6, 4'd7, 1'b0, 16'd257,  2'b00);
  // Square roots, operand_b unused
  define_entry(6,  "sqrt_exact",   SQRT, 16'd144,   16'd0,   4'h7, 4'd0, 1'b0, 16'd12,   2'b00);
  define_entry(7,  "sqrt_inexact", SQRT, 16'd200,   16'd0,   4'h8, 4'd4, 1'b0, 16'd14,   2'b01);
  define_entry(8,  "sqrt_max",     SQRT, 16'd65535, 16'd0,   4'h9, 4'hF, 1'b0, 16'd255,  2'b01);
  define_entry(9,  "sqrt_zero",    SQRT, 16'd0,     16'd0,   4'hA, 4'd0, 1'b0, 16'd0,    2'b00);
  // Flushed operations and the entries right after them
  define_entry(10, "flush_div",    DIV,  16'd5000,  16'd3,   4'hB, 4'd0, 1'b1, 16'd1666, 2'b01);
  define_entry(11, "after_flush",  SQRT, 16'd4096,  16'd0,   4'hC, 4'd1, 1'b0, 16'd64,   2'b00);
  define_entry(12, "flush_sqrt",   SQRT, 16'd50000, 16'd0,   4'hD, 4'd0, 1'b1, 16'd223,  2'b01);
  define_entry(13, "div_post",     DIV,  16'd40000, 16'd123, 4'hE, 4'hF, 1'b0, 16'd325,  2'b01);
  define_entry(14, "sqrt_one",     SQRT, 16'd1,     16'd0,   4'hF, 4'd0, 1'b0, 16'd1,    2'b00);
  define_entry(15, "div_by_self",  DIV,  16'd777,   16'd777, 4'h0, 4'd5, 1'b0, 16'd1,    2'b00);
endtask

`endif

/* dv/dsq_tb.sv */
// ----------------------------------------------------------------------
// Testbench for the divide/square-root unit: clock, reset, table driver,
// back-pressure and flush control, response checks and summary
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module dsq_tb;

  `include "dsq_tb_vectors.svh"

  // Table length plus margin for reset and idle cycles
  localparam int CYCLE_LIMIT = NUM_VECS * 40 + 200;

  logic              clk_i;
  logic              reset_i;
  logic              flush_i;
  dsq_pkg::dsq_req_t in_req_i;
  logic              in_valid_i;
  logic              in_ready_o;
  dsq_pkg::dsq_rsp_t out_rsp_o;
  logic              out_valid_o;
  logic              out_ready_i;
  logic              busy_o;

  int    cycle_cnt  = 0;
  int    pass_count = 0;
  int    fail_count = 0;
  bit    test_ok;
  string cur_test;

  dsq_top u_dsq_top (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .flush_i     (flush_i),
    .in_req_i    (in_req_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_rsp_o   (out_rsp_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  // 100 ns clock
  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  task automatic compare_field(input string field, input logic [15:0] exp_val,
                               input logic [15:0] act_val);
    assert (act_val === exp_val) else begin
      $display("Mismatch %s %s: expected %h, actual %h", cur_test, field, exp_val, act_val);
      test_ok = 1'b0;
    end
  endtask

  task automatic confirm(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("Test %s failed: %s", cur_test, what);
      test_ok = 1'b0;
    end
  endtask

  // Presented response against one table row
  task automatic check_response(input vec_t v);
    compare_field("result", v.exp_result, out_rsp_o.result);
    compare_field("status", {14'd0, v.exp_status}, {14'd0, out_rsp_o.status});
    compare_field("tag", {12'd0, v.tag}, {12'd0, out_rsp_o.tag});
  endtask

  // Integer rules for division and square root
  task automatic reference_result(input vec_t v, output dsq_pkg::operand_t res,
                                  output dsq_pkg::dsq_status_t st);
    int unsigned a;
    int unsigned b;
    int unsigned root;
    a  = 32'(v.a);
    b  = 32'(v.b);
    st = '0;
    if (v.op == DIV) begin
      if (b == 0) begin
        res            = '1;
        st.div_by_zero = 1'b1;
      end else begin
        res        = 16'(a / b);
        st.inexact = (a % b) != 0;
      end
    end else begin
      // Largest root whose square still fits under a
      root = 0;
      while ((root + 1) * (root + 1) <= a) begin
        root = root + 1;
      end
      res        = 16'(root);
      st.inexact = (root * root) != a;
    end
  endtask

  // ----------------------------------------------------------------------
  // Driver and response side
  // ----------------------------------------------------------------------
  task automatic drive_request(input vec_t v);
    dsq_pkg::dsq_req_t req;
    req.op        = v.op;
    req.operand_a = v.a;
    req.operand_b = v.b;
    req.tag       = v.tag;
    @(posedge clk_i);
    in_req_i   <= req;
    in_valid_i <= 1'b1;
    // Accepted on the edge after in_ready_o is seen high
    @(negedge clk_i);
    while (!in_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    in_valid_i <= 1'b0;
  endtask

  task automatic collect_response(input vec_t v, input int stall);
    dsq_pkg::dsq_rsp_t first_rsp;
    @(negedge clk_i);
    while (!out_valid_o) begin
      @(negedge clk_i);
    end
    first_rsp = out_rsp_o;
    // out_ready_i still low, response must sit still
    repeat (stall) begin
      @(negedge clk_i);
      confirm(out_valid_o, "out_valid_o dropped under back-pressure");
      confirm(out_rsp_o === first_rsp, "out_rsp_o changed under back-pressure");
      confirm(busy_o, "busy_o low while a response waits");
    end
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    @(negedge clk_i);
    confirm(out_valid_o, "out_valid_o low when the response was taken");
    confirm(busy_o, "busy_o low before the response was taken");
    check_response(v);
    // Transfer edge
    @(posedge clk_i);
    out_ready_i <= 1'b0;
    @(negedge clk_i);
    confirm(!out_valid_o, "out_valid_o still high after the transfer");
    confirm(!busy_o, "busy_o still high with nothing in flight");
  endtask

  // Next valid response with out_ready_i held high
  task automatic await_and_check(input vec_t v);
    @(negedge clk_i);
    while (!out_valid_o) begin
      @(negedge clk_i);
    end
    check_response(v);
  endtask

  // Second result parks in the hold register behind a stalled output
  // while a third request waits in the input stage
  task automatic check_hold_path(input vec_t a, input vec_t b, input vec_t c);
    dsq_pkg::dsq_rsp_t first_rsp;
    int                wait_cycles;
    wait_cycles = int'((b.op == DIV) ? dsq_pkg::DIV_STEPS : dsq_pkg::SQRT_STEPS) + 3;
    drive_request(a);
    drive_request(b);
    @(negedge clk_i);
    confirm(!in_ready_o, "in_ready_o high with a request waiting in the input stage");
    drive_request(c);
    @(negedge clk_i);
    while (!out_valid_o) begin
      @(negedge clk_i);
    end
    first_rsp = out_rsp_o;
    // Second operation finishes into a full output stage
    repeat (wait_cycles) begin
      @(negedge clk_i);
      confirm(out_valid_o, "out_valid_o dropped under back-pressure");
      confirm(out_rsp_o === first_rsp, "out_rsp_o changed under back-pressure");
      confirm(busy_o, "busy_o low while a response waits");
    end
    confirm(!in_ready_o, "in_ready_o high while a result is held");
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    await_and_check(a);
    await_and_check(b);
    await_and_check(c);
    @(posedge clk_i);
    out_ready_i <= 1'b0;
    @(negedge clk_i);
    confirm(!out_valid_o, "out_valid_o still high after the last transfer");
    confirm(!busy_o, "busy_o still high with nothing in flight");
  endtask

  // Cancel the running operation a few cycles after it starts
  task automatic apply_flush();
    repeat (3) @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(negedge clk_i);
    confirm(!busy_o, "busy_o still high after flush");
    repeat (dsq_pkg::DIV_STEPS + 4) begin
      confirm(!out_valid_o, "response produced for a flushed operation");
      @(negedge clk_i);
    end
  endtask

  task automatic report_test();
    if (test_ok) begin
      pass_count++;
      $display("Test %s passed", cur_test);
    end else begin
      fail_count++;
      $display("Test %s FAILED", cur_test);
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    vec_t                 v;
    dsq_pkg::operand_t    ref_res;
    dsq_pkg::dsq_status_t ref_st;
    int                   stall;

    void'($urandom(74));
    reset_i     <= 1'b1;
    flush_i     <= 1'b0;
    in_req_i    <= '0;
    in_valid_i  <= 1'b0;
    out_ready_i <= 1'b0;
    fill_table();

    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;

    // Idle outputs right after reset
    cur_test = "after_reset";
    test_ok  = 1'b1;
    @(negedge clk_i);
    confirm(in_ready_o, "in_ready_o low after reset");
    confirm(!out_valid_o, "out_valid_o high after reset");
    confirm(!busy_o, "busy_o high after reset");
    report_test();

    for (int i = 0; i < NUM_VECS; i++) begin
      v        = vec_tab[i];
      cur_test = vec_name[i];
      test_ok  = 1'b1;
      // Table row against the integer rules
      reference_result(v, ref_res, ref_st);
      confirm(ref_res === v.exp_result && ref_st === v.exp_status,
              "table entry disagrees with the integer reference");
      drive_request(v);
      if (v.flush) begin
        apply_flush();
      end else begin
        stall = (v.stall == RANDOM_STALL) ? int'($urandom % 8) : int'(v.stall);
        collect_response(v, stall);
      end
      report_test();
    end

    // Deep back-pressure through the sequencer hold register
    cur_test = "hold_register";
    test_ok  = 1'b1;
    check_hold_path(vec_tab[1], vec_tab[7], vec_tab[13]);
    report_test();

    $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+dv
source/dsq_pkg.sv
source/dsq_input_stage.sv
source/dsq_op_sequencer.sv
source/dsq_iter_unit.sv
source/dsq_output_stage.sv
source/dsq_top.sv
dv/dsq_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the dsq testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal --top-module dsq_tb -f src.f -o dsq_sim
./obj_dir/dsq_sim | tee sim.log

if grep -qF '** PASS **' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
